// File: basic_organ.f
organ_pkg.sv
organ_voice.sv
led_chaser.sv
key_repeat.sv
sample_rate_control.sv
hex_display.sv
basic_organ.sv
tb_basic_organ.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_basic_organ
FILELIST  := basic_organ.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_basic_organ.sv
`timescale 1ns/1ps

module tb_basic_organ;

  localparam int CLK_PERIOD      = 20;
  localparam int CLK_HZ          = 100_000;
  localparam int LED_STEP_CYCLES = 40;
  localparam int REPEAT_CYCLES   = 30;
  localparam int REFRESH_CYCLES  = 50;
  localparam int RESET_CYCLES    = 10;
  localparam int SEED            = 73860;

  // Model limits for the sampling count
  localparam int COUNT_DEFAULT = 12499;
  localparam int COUNT_STEP    = 100;
  localparam int COUNT_MIN     = 99;
  localparam int COUNT_MAX     = 65499;

  // ========================================
  // Test lengths in cycles
  // ========================================
  localparam int NUM_NOTES   = 12;
  localparam int RISE_LIMIT  = 4 * (CLK_HZ / (2 * 523));
  localparam int OFF_CYCLES  = 500;
  localparam int LED_WINDOW  = 400;
  localparam int NUM_PRESSES = 30;
  localparam int SETTLE      = REFRESH_CYCLES + 10;
  localparam int HOLD_MAX    = 902;
  localparam int TEST_CYCLES = RESET_CYCLES + 2 * SETTLE
                             + NUM_NOTES * (3 * RISE_LIMIT + 2)
                             + OFF_CYCLES + 4 + LED_WINDOW + 2
                             + NUM_PRESSES * (REPEAT_CYCLES + SETTLE + 2)
                             + HOLD_MAX + 8 + 2 * (SETTLE + 2);

  localparam int NOTE_FREQ [8] = '{523, 587, 659, 698, 783, 880, 987, 1047};

  localparam logic [31:0] NOTE_TEXT [8] = '{
    "Do  ", "Re  ", "Mi  ", "Fa  ", "So  ", "La  ", "Ti  ", "DO2 "
  };
  localparam logic [31:0] OFF_TEXT = "OFF ";

  // Lit segments, active high, bit order g f e d c b a
  localparam logic [6:0] LIT_SEGS [16] = '{
    7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
  };

  logic        CLK_50M;
  logic        reset;
  logic [3:0]  sw;
  logic [2:0]  key;
  logic        tone;
  logic [31:0] note_label;
  logic [7:0]  led;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;

  int errors;
  int checks;
  int model_count;

  basic_organ #(
    .CLK_HZ         (CLK_HZ),
    .LED_STEP_CYCLES(LED_STEP_CYCLES),
    .REPEAT_CYCLES  (REPEAT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) i_basic_organ (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .sw        (sw),
    .key       (key),
    .tone      (tone),
    .note_label(note_label),
    .led       (led),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .hex4      (hex4),
    .hex5      (hex5)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;
  end

  // Watchdog
  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, %0d errors so far", 2 * TEST_CYCLES, errors);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic int led_index(input logic [7:0] value);
    int idx;
    idx = -1;
    for (int i = 0; i < 8; i++)
    begin
      if (value[3'(i)])
        idx = i;
    end
    return idx;
  endfunction

  // Key 0 is up, 1 is down, 2 is restore
  function automatic int step_model(input int count, input logic [1:0] which);
    int stepped;
    stepped = count;
    if (which == 2'd2)
      stepped = COUNT_DEFAULT;
    else if (which == 2'd0 && count + COUNT_STEP <= COUNT_MAX)
      stepped = count + COUNT_STEP;
    else if (which == 2'd1 && count - COUNT_STEP >= COUNT_MIN)
      stepped = count - COUNT_STEP;
    return stepped;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK_50M);
  endtask

  task automatic press_key(input logic [1:0] which, input int hold);
    @(posedge CLK_50M);
    key[which] <= 1'b0;
    repeat (hold) @(posedge CLK_50M);
    key <= 3'b111;
  endtask

  // Cycles until the next rising edge of tone, -1 if none shows up
  task automatic cycles_to_tone_rise(output int cycles);
    logic prev;
    bit   seen;
    cycles = 0;
    seen   = 1'b0;
    prev   = tone;
    while (!seen && cycles < RISE_LIMIT)
    begin
      @(negedge CLK_50M);
      cycles++;
      seen = !prev && tone;
      prev = tone;
    end
    if (!seen)
      cycles = -1;
  endtask

  task automatic check_display(input logic [23:0] value, input string what);
    logic [41:0] all_segs;
    logic [6:0]  got;
    logic [6:0]  want;
    logic [3:0]  nib;
    all_segs = {hex5, hex4, hex3, hex2, hex1, hex0};
    for (int i = 0; i < 6; i++)
    begin
      nib  = 4'(value >> (4 * i));
      got  = 7'(all_segs >> (7 * i));
      want = ~LIT_SEGS[nib];
      checks++;
      if (got !== want)
      begin
        errors++;
        $display("[FAIL] %0t hex%0d (%s): expected %b, got %b", $time, i, what, want, got);
      end
    end
  endtask

  initial
  begin
    int          hold;
    int          cycles;
    int          period;
    int          pulses;
    int          prev_idx;
    int          idx;
    logic [2:0]  note;
    logic [1:0]  which;

    errors      = 0;
    checks      = 0;
    void'($urandom(SEED));
    reset       = 1'b1;
    sw          = 4'b0000;
    key         = 3'b111;
    model_count = COUNT_DEFAULT;

    repeat (RESET_CYCLES) @(posedge CLK_50M);
    reset <= 1'b0;

    // ========================================
    // Reset state and first refresh
    // ========================================
    @(negedge CLK_50M);
    checks++;
    if (led !== 8'b0000_0001)
    begin
      errors++;
      $display("[FAIL] %0t led: expected %b, got %b", $time, 8'b0000_0001, led);
    end
    check_display(24'h000000, "before refresh");
    wait_cycles(SETTLE);
    @(negedge CLK_50M);
    check_display(24'h0030D3, "first refresh");

    // Tone period and label for random notes
    for (int n = 0; n < NUM_NOTES; n++)
    begin
      note = 3'($urandom_range(0, 7));
      @(posedge CLK_50M);
      sw <= {note, 1'b1};
      @(negedge CLK_50M);
      checks++;
      if (note_label !== NOTE_TEXT[note])
      begin
        errors++;
        $display("[FAIL] %0t note_label: expected \"%s\", got \"%s\"",
                 $time, NOTE_TEXT[note], note_label);
      end
      period = 2 * (CLK_HZ / (2 * NOTE_FREQ[note]));
      // Line up on a rising edge first
      cycles_to_tone_rise(cycles);
      for (int m = 0; m < 2; m++)
      begin
        cycles_to_tone_rise(cycles);
        checks++;
        if (cycles != period)
        begin
          errors++;
          $display("[FAIL] %0t tone period (note %0d): expected %0d, got %0d",
                   $time, note, period, cycles);
        end
      end
    end

    // Note off
    @(posedge CLK_50M);
    sw <= {3'($urandom_range(0, 7)), 1'b0};
    wait_cycles(2);
    for (int c = 0; c < OFF_CYCLES; c++)
    begin
      @(negedge CLK_50M);
      checks++;
      if (tone !== 1'b0)
      begin
        errors++;
        $display("[FAIL] %0t tone: expected %b, got %b", $time, 1'b0, tone);
      end
      if (note_label !== OFF_TEXT)
      begin
        errors++;
        $display("[FAIL] %0t note_label: expected \"%s\", got \"%s\"",
                 $time, OFF_TEXT, note_label);
      end
    end

    // ========================================
    // Walking LED
    // ========================================
    prev_idx = led_index(led);
    for (int c = 1; c <= LED_WINDOW; c++)
    begin
      @(negedge CLK_50M);
      checks++;
      if ($countones(led) != 1)
      begin
        errors++;
        $display("[FAIL] %0t led: expected one lit bit, got %b", $time, led);
      end
      if (c % LED_STEP_CYCLES == 0)
      begin
        idx = led_index(led);
        checks++;
        if (idx != (prev_idx + 1) % 8)
        begin
          errors++;
          $display("[FAIL] %0t led index: expected %0d, got %0d",
                   $time, (prev_idx + 1) % 8, idx);
        end
        prev_idx = idx;
      end
    end

    // Short presses, one step each
    for (int p = 0; p < NUM_PRESSES; p++)
    begin
      which = 2'($urandom_range(0, 2));
      hold  = $urandom_range(1, REPEAT_CYCLES - 1);
      press_key(which, hold);
      model_count = step_model(model_count, which);
      wait_cycles(SETTLE);
      @(negedge CLK_50M);
      check_display(24'(model_count), "short press");
    end

    // ========================================
    // Held up key with auto-repeat
    // ========================================
    hold = $urandom_range(200, 900);
    // Keep the hold clear of a repeat boundary
    if ((hold - 1) % REPEAT_CYCLES < 2)
      hold = hold + 2;
    pulses = 1 + (hold - 3) / REPEAT_CYCLES;
    for (int s = 0; s < pulses; s++)
    begin
      model_count = step_model(model_count, 2'd0);
    end
    press_key(2'd0, hold);
    wait_cycles(SETTLE);
    @(negedge CLK_50M);
    check_display(24'(model_count), "held up key");

    press_key(2'd2, 5);
    model_count = step_model(model_count, 2'd2);
    wait_cycles(SETTLE);
    @(negedge CLK_50M);
    check_display(24'h0030D3, "restore");

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: basic_organ.sv
`timescale 1ns/1ps

module basic_organ #(
  parameter int CLK_HZ          = 50_000_000,
  parameter int LED_STEP_CYCLES = 50_000_000,
  parameter int REPEAT_CYCLES   = 5_000_000,
  parameter int REFRESH_CYCLES  = 25_000_000
) (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic [3:0]        sw,
  input  logic [2:0]        key,
  output logic              tone,
  output organ_pkg::label_t note_label,
  output logic [7:0]        led,
  output organ_pkg::seg_t   hex0,
  output organ_pkg::seg_t   hex1,
  output organ_pkg::seg_t   hex2,
  output organ_pkg::seg_t   hex3,
  output organ_pkg::seg_t   hex4,
  output organ_pkg::seg_t   hex5
);

  import organ_pkg::*;

  logic          up_pulse;
  logic          down_pulse;
  logic          restore;
  sample_count_t sample_count;

  // ========================================
  // Tone and LEDs
  // ========================================
  organ_voice #(
    .CLK_HZ(CLK_HZ)
  ) i_organ_voice (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .sw        (sw),
    .tone      (tone),
    .note_label(note_label)
  );

  led_chaser #(
    .LED_STEP_CYCLES(LED_STEP_CYCLES)
  ) i_led_chaser (
    .CLK_50M(CLK_50M),
    .reset  (reset),
    .led    (led)
  );

  // ========================================
  // Sampling count path
  // ========================================
  key_repeat #(
    .REPEAT_CYCLES(REPEAT_CYCLES)
  ) i_key_repeat (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .key       (key),
    .up_pulse  (up_pulse),
    .down_pulse(down_pulse),
    .restore   (restore)
  );

  sample_rate_control i_sample_rate_control (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .up_pulse    (up_pulse),
    .down_pulse  (down_pulse),
    .restore     (restore),
    .sample_count(sample_count)
  );

  hex_display #(
    .REFRESH_CYCLES(REFRESH_CYCLES)
  ) i_hex_display (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .sample_count(sample_count),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5)
  );

endmodule

// File: hex_display.sv
`timescale 1ns/1ps

module hex_display #(
  parameter int REFRESH_CYCLES = 25_000_000
) (
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  organ_pkg::sample_count_t sample_count,
  output organ_pkg::seg_t          hex0,
  output organ_pkg::seg_t          hex1,
  output organ_pkg::seg_t          hex2,
  output organ_pkg::seg_t          hex3,
  output organ_pkg::seg_t          hex4,
  output organ_pkg::seg_t          hex5
);

  import organ_pkg::*;

  localparam int REFRESH_W = $clog2(REFRESH_CYCLES);
  localparam int SHOWN_W   = HEX_DIGITS * 4;

  function automatic seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  logic [REFRESH_W-1:0] refresh_count;
  logic [SHOWN_W-1:0]   shown;
  seg_t                 digit_seg [HEX_DIGITS];

  // Slow latch keeps the digits readable
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      refresh_count <= '0;
      shown         <= '0;
    end
    else if (refresh_count == REFRESH_W'(REFRESH_CYCLES - 1))
    begin
      refresh_count <= '0;
      shown         <= {{(SHOWN_W - $bits(sample_count_t)){1'b0}}, sample_count};
    end
    else
    begin
      refresh_count <= refresh_count + 1'b1;
    end
  end

  for (genvar i = 0; i < HEX_DIGITS; i++)
  begin : g_digit
    assign digit_seg[i] = seg_decode(shown[i*4 +: 4]);
  end

  assign hex0 = digit_seg[0];
  assign hex1 = digit_seg[1];
  assign hex2 = digit_seg[2];
  assign hex3 = digit_seg[3];
  assign hex4 = digit_seg[4];
  assign hex5 = digit_seg[5];

endmodule

// File: sample_rate_control.sv
`timescale 1ns/1ps

module sample_rate_control (
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  logic                     up_pulse,
  input  logic                     down_pulse,
  input  logic                     restore,
  output organ_pkg::sample_count_t sample_count
);

  import organ_pkg::*;

  logic up_ok;
  logic down_ok;

  // Steps that would leave the legal range are dropped
  assign up_ok   = sample_count <= SAMPLE_COUNT_MAX - SAMPLE_STEP;
  assign down_ok = sample_count >= SAMPLE_COUNT_MIN + SAMPLE_STEP;

  always_ff @(posedge CLK_50M)
  begin
    if (reset || restore)
    begin
      sample_count <= SAMPLE_COUNT_DEFAULT;
    end
    else if (up_pulse)
    begin
      // Up wins, down in the same cycle is lost
      if (up_ok)
        sample_count <= sample_count + SAMPLE_STEP;
    end
    else if (down_pulse)
    begin
      if (down_ok)
        sample_count <= sample_count - SAMPLE_STEP;
    end
  end

  a_count_in_range: assert property (
    @(posedge CLK_50M) disable iff (reset)
      sample_count >= SAMPLE_COUNT_MIN && sample_count <= SAMPLE_COUNT_MAX
  );

endmodule

// File: key_repeat.sv
`timescale 1ns/1ps

module key_repeat #(
  parameter int REPEAT_CYCLES = 5_000_000
) (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic [2:0] key,
  output logic       up_pulse,
  output logic       down_pulse,
  output logic       restore
);

  localparam int CNT_W = $clog2(REPEAT_CYCLES + 1);

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [1:0]       dir_held;
  logic [1:0]       dir_held_d;
  logic [1:0]       dir_fire;
  logic [1:0]       dir_pulse;
  logic [CNT_W-1:0] repeat_count [2];

  // Keys are active low, sync stores the pressed level
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key;
      key_sync <= key_meta;
    end
  end

  // Index 0 is up, index 1 is down
  assign dir_held = key_sync[1:0];

  always_comb
  begin
    for (int d = 0; d < 2; d++)
    begin
      dir_fire[d] = dir_held[d] &&
                    (!dir_held_d[d] || repeat_count[d] == CNT_W'(REPEAT_CYCLES));
    end
  end

  // ========================================
  // Repeat counters and pulse registers
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      dir_held_d <= '0;
      dir_pulse  <= '0;
      for (int d = 0; d < 2; d++)
      begin
        repeat_count[d] <= '0;
      end
    end
    else
    begin
      dir_held_d <= dir_held;
      dir_pulse  <= dir_fire;
      for (int d = 0; d < 2; d++)
      begin
        if (!dir_held[d])
          repeat_count[d] <= '0;
        else if (dir_fire[d])
          repeat_count[d] <= CNT_W'(1);
        else
          repeat_count[d] <= repeat_count[d] + 1'b1;
      end
    end
  end

  assign up_pulse   = dir_pulse[0];
  assign down_pulse = dir_pulse[1];
  assign restore    = key_sync[2];

  a_up_single: assert property (
    @(posedge CLK_50M) disable iff (reset) up_pulse |=> !up_pulse
  );

  a_down_single: assert property (
    @(posedge CLK_50M) disable iff (reset) down_pulse |=> !down_pulse
  );

endmodule

// File: led_chaser.sv
`timescale 1ns/1ps

module led_chaser #(
  parameter int LED_STEP_CYCLES = 50_000_000
) (
  input  logic       CLK_50M,
  input  logic       reset,
  output logic [7:0] led
);

  localparam int STEP_W = $clog2(LED_STEP_CYCLES);

  logic [STEP_W-1:0] step_count;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      step_count <= '0;
      led        <= 8'b0000_0001;
    end
    else if (step_count == STEP_W'(LED_STEP_CYCLES - 1))
    begin
      step_count <= '0;
      // Step left, bit 7 wraps to bit 0
      led        <= {led[6:0], led[7]};
    end
    else
    begin
      step_count <= step_count + 1'b1;
    end
  end

  a_led_onehot: assert property (
    @(posedge CLK_50M) disable iff (reset) $onehot(led)
  );

endmodule

// File: organ_voice.sv
`timescale 1ns/1ps

module organ_voice #(
  parameter int CLK_HZ = 50_000_000
) (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic [3:0]        sw,
  output logic              tone,
  output organ_pkg::label_t note_label
);

  import organ_pkg::*;

  // Longest half period belongs to the lowest note
  localparam int HALF_W = $clog2(CLK_HZ / (2 * int'(NOTE_HZ[0])) + 1);

  typedef logic [HALF_W-1:0] half_table_t [NOTE_COUNT];

  function automatic half_table_t build_half_table();
    half_table_t tbl;
    for (int i = 0; i < NOTE_COUNT; i++)
    begin
      tbl[i] = HALF_W'(CLK_HZ / (2 * int'(NOTE_HZ[i])));
    end
    return tbl;
  endfunction

  localparam half_table_t HALF_PERIOD = build_half_table();

  logic              note_on;
  note_sel_t         note_sel;
  note_sel_t         note_sel_d;
  logic [HALF_W-1:0] half_period;
  logic [HALF_W-1:0] half_count;

  assign note_on     = sw[0];
  assign note_sel    = note_sel_t'(sw[3:1]);
  assign half_period = HALF_PERIOD[note_sel];

  // ========================================
  // Square wave generator
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tone       <= 1'b0;
      half_count <= '0;
      note_sel_d <= '0;
    end
    else
    begin
      note_sel_d <= note_sel;
      if (!note_on)
      begin
        tone       <= 1'b0;
        half_count <= '0;
      end
      else if (note_sel != note_sel_d)
      begin
        // New note, start the half period over
        half_count <= '0;
      end
      else if (half_count == half_period - 1'b1)
      begin
        half_count <= '0;
        tone       <= ~tone;
      end
      else
      begin
        half_count <= half_count + 1'b1;
      end
    end
  end

  // Label lookup
  always_comb
  begin
    if (note_on)
      note_label = NOTE_LABEL[note_sel];
    else
      note_label = LABEL_OFF;
  end

  a_tone_quiet_when_off: assert property (
    @(posedge CLK_50M) disable iff (reset) !note_on |=> !tone
  );

endmodule

// File: organ_pkg.sv
package organ_pkg;

  // ========================================
  // Note table
  // ========================================
  typedef logic [10:0] note_hz_t;
  typedef logic [2:0]  note_sel_t;

  localparam int NOTE_COUNT = 8;

  // Do up to high Do, in Hz
  localparam note_hz_t NOTE_HZ [NOTE_COUNT] = '{
    11'd523, 11'd587, 11'd659, 11'd698,
    11'd783, 11'd880, 11'd987, 11'd1047
  };

  // ========================================
  // Characters and note labels
  // ========================================
  typedef logic [7:0]  ascii_t;
  typedef logic [31:0] label_t;

  localparam ascii_t CHAR_SPACE   = 8'h20;
  localparam ascii_t CHAR_2       = 8'h32;
  localparam ascii_t CHAR_D       = 8'h44;
  localparam ascii_t CHAR_F       = 8'h46;
  localparam ascii_t CHAR_L       = 8'h4C;
  localparam ascii_t CHAR_M       = 8'h4D;
  localparam ascii_t CHAR_O       = 8'h4F;
  localparam ascii_t CHAR_R       = 8'h52;
  localparam ascii_t CHAR_S       = 8'h53;
  localparam ascii_t CHAR_T       = 8'h54;
  localparam ascii_t CHAR_LOWER_A = 8'h61;
  localparam ascii_t CHAR_LOWER_E = 8'h65;
  localparam ascii_t CHAR_LOWER_I = 8'h69;
  localparam ascii_t CHAR_LOWER_O = 8'h6F;

  // First character sits in the top byte
  localparam label_t NOTE_LABEL [NOTE_COUNT] = '{
    {CHAR_D, CHAR_LOWER_O, CHAR_SPACE, CHAR_SPACE},
    {CHAR_R, CHAR_LOWER_E, CHAR_SPACE, CHAR_SPACE},
    {CHAR_M, CHAR_LOWER_I, CHAR_SPACE, CHAR_SPACE},
    {CHAR_F, CHAR_LOWER_A, CHAR_SPACE, CHAR_SPACE},
    {CHAR_S, CHAR_LOWER_O, CHAR_SPACE, CHAR_SPACE},
    {CHAR_L, CHAR_LOWER_A, CHAR_SPACE, CHAR_SPACE},
    {CHAR_T, CHAR_LOWER_I, CHAR_SPACE, CHAR_SPACE},
    {CHAR_D, CHAR_O,       CHAR_2,     CHAR_SPACE}
  };

  localparam label_t LABEL_OFF = {CHAR_O, CHAR_F, CHAR_F, CHAR_SPACE};

  // ========================================
  // Sampling count and displays
  // ========================================
  typedef logic [15:0] sample_count_t;

  localparam sample_count_t SAMPLE_COUNT_DEFAULT = 16'd12499;
  localparam sample_count_t SAMPLE_STEP          = 16'd100;
  localparam sample_count_t SAMPLE_COUNT_MIN     = 16'd99;
  localparam sample_count_t SAMPLE_COUNT_MAX     = 16'd65499;

  localparam int HEX_DIGITS = 6;

  // Active low, bit order g f e d c b a
  typedef logic [6:0] seg_t;

endpackage
